/* sources.f */
source/des_pkg.sv
source/des_key_if.sv
source/des_round.sv
source/des_key_schedule.sv
source/des_core.sv
source/des_top.sv
test/des_tb.sv

/* Makefile */
TOP = des_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f sources.f --top-module des_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/des_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module des_tb import des_pkg::*; ();

  localparam int NUM_RANDOM = 300;
  localparam int MAX_OPS    = 2 * NUM_RANDOM + 10;  // each encryption may be followed by its inverse.
  localparam int MAX_CYCLES = MAX_OPS * 20 + 200;

  logic   CLK = 1'b0;
  logic   RST;
  logic   key_load;
  key_t   key_in;
  logic   start;
  logic   decrypt;
  block_t block_in;
  block_t block_out;
  logic   done;
  logic   busy;

  logic [31:0] rng_state = 32'hfe09_e772;
  int          cycle_count = 0;
  key_t        cur_key;
  round_key_t  model_keys [16];

  des_top UUT (
    .CLK       (CLK),
    .RST       (RST),
    .key_load  (key_load),
    .key_in    (key_in),
    .start     (start),
    .decrypt   (decrypt),
    .block_in  (block_in),
    .block_out (block_out),
    .done      (done),
    .busy      (busy)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish.", cycle_count);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  function automatic block_t model_ip(input block_t b);
    block_t o;
    o = '0;
    for (int i = 0; i < 64; i++) begin
      o = {o[62:0], b[64 - IP_TABLE[i]]};
    end
    return o;
  endfunction

  function automatic block_t model_fp(input block_t b);
    block_t o;
    o = '0;
    for (int i = 0; i < 64; i++) begin
      o = {o[62:0], b[64 - FP_TABLE[i]]};
    end
    return o;
  endfunction

  function automatic half_t model_f(input half_t r, input round_key_t k);
    expand_t    x;
    half_t      s;
    half_t      p;
    logic [5:0] six;
    int         row;
    int         col;
    x = '0;
    s = '0;
    p = '0;
    for (int i = 0; i < 48; i++) begin
      x = {x[46:0], r[32 - E_TABLE[i]]};
    end
    x = x ^ k;
    for (int b = 0; b < 8; b++) begin
      six = x[47 - 6 * b -: 6];
      row = 2 * six[5] + six[0];
      col = six[4:1];
      s = {s[27:0], SBOX[b][row * 16 + col]};
    end
    for (int i = 0; i < 32; i++) begin
      p = {p[30:0], s[32 - P_TABLE[i]]};
    end
    return p;
  endfunction

  // fills model_keys with the sixteen encryption subkeys.
  function automatic void make_keys(input key_t k);
    logic [55:0] cd;
    cd_t         c;
    cd_t         d;
    round_key_t  sub;
    cd = '0;
    for (int i = 0; i < 56; i++) begin
      cd = {cd[54:0], k[64 - PC1_TABLE[i]]};
    end
    c = cd[55:28];
    d = cd[27:0];
    for (int r = 0; r < 16; r++) begin
      for (int n = 0; n < SHIFT_TABLE[r]; n++) begin
        c = {c[26:0], c[27]};
        d = {d[26:0], d[27]};
      end
      cd = {c, d};
      sub = '0;
      for (int i = 0; i < 48; i++) begin
        sub = {sub[46:0], cd[56 - PC2_TABLE[i]]};
      end
      model_keys[r] = sub;
    end
  endfunction

  function automatic block_t des_model(input key_t k, input block_t blk, input logic dec);
    block_t x;
    half_t  l;
    half_t  r;
    half_t  t;
    make_keys(k);
    x = model_ip(blk);
    l = x[63:32];
    r = x[31:0];
    for (int i = 0; i < 16; i++) begin
      t = r;
      r = l ^ model_f(r, dec ? model_keys[15 - i] : model_keys[i]);
      l = t;
    end
    return model_fp({r, l});
  endfunction

  task automatic load_key(input key_t k);
    key_in   = k;
    key_load = 1'b1;
    @(negedge CLK);
    key_load = 1'b0;
    cur_key  = k;
  endtask

  // starts one block and follows it to done, optionally disturbing it on the way.
  task automatic run_block(input block_t blk, input logic dec, input int extra_at,
                           input block_t extra_blk, input int key_at, input key_t new_key,
                           output block_t res);
    int edges;
    block_in = blk;
    decrypt  = dec;
    start    = 1'b1;
    @(negedge CLK);
    edges = 0;
    while (done !== 1'b1) begin
      check_value("busy", busy, 64'd1);
      start    = 1'b0;
      key_load = 1'b0;
      if (edges == extra_at) begin
        start    = 1'b1;
        block_in = extra_blk;
        decrypt  = ~dec;
      end
      if (edges == key_at) begin
        key_load = 1'b1;
        key_in   = new_key;
      end
      @(negedge CLK);
      edges++;
      if (edges > 40) begin
        $display("done never came back for block %h.", blk);
        $display("Testbench failed");
        $fatal(1);
      end
    end
    start    = 1'b0;
    key_load = 1'b0;
    check_value("done latency", 64'(edges), 64'd16);
    check_value("busy", busy, 64'd0);
    res = block_out;
  endtask

  initial begin
    block_t res;
    block_t back;
    block_t blk;
    key_t   k2;
    logic   dec;
    logic [31:0] rnd;
    RST      = 1'b0;
    key_load = 1'b0;
    key_in   = '0;
    start    = 1'b0;
    decrypt  = 1'b0;
    block_in = '0;
    repeat (5) @(negedge CLK);
    RST = 1'b1;
    check_value("busy", busy, 64'd0);
    check_value("done", done, 64'd0);
    check_value("block_out", block_out, 64'd0);

    load_key(64'h1334_5779_9BBC_DFF1);
    run_block(64'h0123_4567_89AB_CDEF, 1'b0, -1, '0, -1, '0, res);
    check_value("block_out", res, 64'h85E8_1354_0F0A_B405);
    run_block(64'h85E8_1354_0F0A_B405, 1'b1, -1, '0, -1, '0, res);
    check_value("block_out", res, 64'h0123_4567_89AB_CDEF);

    // a second start in flight must not disturb the first block.
    blk = {next_rand(), next_rand()};
    run_block(blk, 1'b0, 5, {next_rand(), next_rand()}, -1, '0, res);
    check_value("block_out", res, des_model(cur_key, blk, 1'b0));
    repeat (20) begin
      @(negedge CLK);
      check_value("done", done, 64'd0);
      check_value("busy", busy, 64'd0);
    end

    blk = {next_rand(), next_rand()};
    k2  = {next_rand(), next_rand()};
    run_block(blk, 1'b1, -1, '0, 7, k2, res);
    check_value("block_out", res, des_model(cur_key, blk, 1'b1));
    cur_key = k2;
    run_block(blk, 1'b1, -1, '0, -1, '0, res);
    check_value("block_out", res, des_model(cur_key, blk, 1'b1));

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd = next_rand();
      if (rnd[30:28] != 3'd0) begin
        load_key({next_rand(), next_rand()});
      end
      blk = {next_rand(), next_rand()};
      dec = rnd[31];
      run_block(blk, dec, -1, '0, -1, '0, res);
      check_value("block_out", res, des_model(cur_key, blk, dec));
      if (!dec) begin
        run_block(res, 1'b1, -1, '0, -1, '0, back);
        check_value("block_out", back, blk);  // decryption undoes the encryption.
      end
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/des_top.sv */
`timescale 1ns/1ns
`default_nettype none

module des_top import des_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  logic   key_load,
  input  key_t   key_in,
  input  logic   start,
  input  logic   decrypt,
  input  block_t block_in,
  output block_t block_out,
  output logic   done,
  output logic   busy
);

  des_key_if key_bus ();

  des_core u_core (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .decrypt   (decrypt),
    .block_in  (block_in),
    .block_out (block_out),
    .done      (done),
    .busy      (busy),
    .key_bus   (key_bus)
  );

  des_key_schedule u_sched (
    .CLK      (CLK),
    .RST      (RST),
    .key_load (key_load),
    .key_in   (key_in),
    .key_bus  (key_bus)
  );

endmodule

`default_nettype wire

/* source/des_core.sv */
`timescale 1ns/1ns
`default_nettype none

module des_core import des_pkg::*; (
  input  logic    CLK,
  input  logic    RST,
  input  logic    start,
  input  logic    decrypt,
  input  block_t  block_in,
  output block_t  block_out,
  output logic    done,
  output logic    busy,
  des_key_if.ctrl key_bus
);

  core_state_t state_q;
  round_idx_t  round_q;
  half_t       l_q;
  half_t       r_q;
  half_t       l_next;
  half_t       r_next;
  logic        decrypt_q;
  logic        accept;
  logic        last_round;
  block_t      ip_block;
  block_t      preout;
  block_t      fp_block;

  des_round u_round (
    .left       (l_q),
    .right      (r_q),
    .round_key  (key_bus.round_key),
    .left_next  (l_next),
    .right_next (r_next)
  );

  assign accept     = start && (state_q == st_idle);  // starts while busy are dropped.
  assign last_round = (round_q == round_idx_t'(NUM_ROUNDS - 1));

  assign key_bus.load    = accept;
  assign key_bus.step    = (state_q == st_run);
  assign key_bus.decrypt = decrypt_q;

  // the last round has no swap, so the halves go back in R16 L16 order.
  assign preout = {r_next, l_next};

  always_comb begin
    for (int i = 0; i < 64; i++) begin
      ip_block[63 - i] = block_in[64 - IP_TABLE[i]];
      fp_block[63 - i] = preout[64 - FP_TABLE[i]];
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      l_q <= ip_block[63:32];
      r_q <= ip_block[31:0];
    end else if (state_q == st_run) begin
      l_q <= l_next;
      r_q <= r_next;
    end
  end

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      state_q   <= st_idle;
      round_q   <= '0;
      decrypt_q <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      block_out <= '0;
    end else begin
      done <= 1'b0;
      case (state_q)
        st_idle: begin
          if (accept) begin
            state_q   <= st_run;
            round_q   <= '0;
            decrypt_q <= decrypt;
            busy      <= 1'b1;
          end
        end
        st_run: begin
          round_q <= round_q + 1'b1;  // wraps back to zero after round 16.
          if (last_round) begin
            state_q   <= st_idle;
            busy      <= 1'b0;
            done      <= 1'b1;
            block_out <= fp_block;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  a_done_single: assert property (@(posedge CLK) disable iff (!RST) done |=> !done);

  a_idle_round: assert property (@(posedge CLK) disable iff (!RST)
    (state_q == st_idle) |-> (round_q == '0));

  a_busy_run: assert property (@(posedge CLK) disable iff (!RST)
    busy == (state_q == st_run));

endmodule

`default_nettype wire

/* source/des_key_schedule.sv */
`timescale 1ns/1ns
`default_nettype none

module des_key_schedule import des_pkg::*; (
  input  logic     CLK,
  input  logic     RST,
  input  logic     key_load,
  input  key_t     key_in,
  des_key_if.sched key_bus
);

  key_t        key_q;
  cd_t         c_q;
  cd_t         d_q;
  round_idx_t  count_q;
  logic        primed_q;
  cd_t         c_fwd;
  cd_t         d_fwd;
  cd_t         c_bwd;
  cd_t         d_bwd;
  logic [55:0] cd_pc1;
  logic [55:0] cd_sel;

  function automatic cd_t rotl(input cd_t v, input int n);
    return (v << n) | (v >> (28 - n));
  endfunction

  function automatic cd_t rotr(input cd_t v, input int n);
    return (v >> n) | (v << (28 - n));
  endfunction

  always_comb begin
    for (int i = 0; i < 56; i++) begin
      cd_pc1[55 - i] = key_q[64 - PC1_TABLE[i]];
    end
  end

  // encryption rotates ahead of the key, decryption walks back after it.
  assign c_fwd = rotl(c_q, SHIFT_TABLE[count_q]);
  assign d_fwd = rotl(d_q, SHIFT_TABLE[count_q]);
  assign c_bwd = rotr(c_q, SHIFT_TABLE[NUM_ROUNDS - 1 - count_q]);
  assign d_bwd = rotr(d_q, SHIFT_TABLE[NUM_ROUNDS - 1 - count_q]);

  assign cd_sel = key_bus.decrypt ? {c_q, d_q} : {c_fwd, d_fwd};

  always_comb begin
    for (int i = 0; i < 48; i++) begin
      key_bus.round_key[47 - i] = cd_sel[56 - PC2_TABLE[i]];
    end
  end

  always_ff @(posedge CLK) begin
    if (key_load) begin
      key_q <= key_in;
    end
  end

  always_ff @(posedge CLK) begin
    if (key_bus.load) begin
      c_q <= cd_pc1[55:28];
      d_q <= cd_pc1[27:0];
    end else if (key_bus.step) begin
      c_q <= key_bus.decrypt ? c_bwd : c_fwd;
      d_q <= key_bus.decrypt ? d_bwd : d_fwd;
    end
  end

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      count_q  <= '0;
      primed_q <= 1'b0;
    end else if (key_bus.load) begin
      count_q  <= '0;
      primed_q <= 1'b1;
    end else if (key_bus.step) begin
      count_q <= count_q + 1'b1;
    end
  end

  // the core must never step C/D before it has copied a key into them.
  a_step_after_load: assert property (@(posedge CLK) disable iff (!RST)
    key_bus.step |-> primed_q);

endmodule

`default_nettype wire

/* source/des_round.sv */
`timescale 1ns/1ns
`default_nettype none

module des_round import des_pkg::*; (
  input  half_t      left,
  input  half_t      right,
  input  round_key_t round_key,
  output half_t      left_next,
  output half_t      right_next
);

  expand_t    expanded;
  expand_t    mixed;
  half_t      sbox_out;
  half_t      f_out;
  logic [5:0] six;

  always_comb begin
    for (int i = 0; i < 48; i++) begin
      expanded[47 - i] = right[32 - E_TABLE[i]];
    end
  end

  assign mixed = expanded ^ round_key;

  // outer bits pick the row and the inner four the column.
  always_comb begin
    six = '0;
    for (int k = 0; k < 8; k++) begin
      six = mixed[47 - 6 * k -: 6];
      sbox_out[31 - 4 * k -: 4] = SBOX[k][{six[5], six[0], six[4:1]}];
    end
  end

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      f_out[31 - i] = sbox_out[32 - P_TABLE[i]];
    end
  end

  assign left_next  = right;
  assign right_next = left ^ f_out;

endmodule

`default_nettype wire

/* source/des_key_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface des_key_if import des_pkg::*; ();

  logic       load;      // copy the key register into C/D.
  logic       step;      // advance C/D by one round.
  logic       decrypt;
  round_key_t round_key;

  modport ctrl (
    output load,
    output step,
    output decrypt,
    input  round_key
  );

  modport sched (
    input  load,
    input  step,
    input  decrypt,
    output round_key
  );

endinterface

`default_nettype wire

/* source/des_pkg.sv */
`default_nettype none

package des_pkg;

  typedef logic [63:0] block_t;
  typedef logic [31:0] half_t;
  typedef logic [63:0] key_t;       // the user key still carries its parity bits.
  typedef logic [27:0] cd_t;
  typedef logic [47:0] round_key_t;
  typedef logic [47:0] expand_t;
  typedef logic [3:0]  round_idx_t;

  typedef enum logic {
    st_idle,
    st_run
  } core_state_t;

  localparam int NUM_ROUNDS = 16;

  // all tables number bits from 1 upward and bit 1 is the msb.
  localparam int IP_TABLE [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2,
    60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6,
    64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17,  9, 1,
    59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5,
    63, 55, 47, 39, 31, 23, 15, 7
  };

  localparam int FP_TABLE [64] = '{
    40, 8, 48, 16, 56, 24, 64, 32,
    39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30,
    37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28,
    35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26,
    33, 1, 41,  9, 49, 17, 57, 25
  };

  localparam int E_TABLE [48] = '{
    32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
     8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
  };

  localparam int P_TABLE [32] = '{
    16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
  };

  localparam int PC1_TABLE [56] = '{
    57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
  };

  localparam int PC2_TABLE [48] = '{
    14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
    23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  localparam int SHIFT_TABLE [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

  // entry index is row * 16 + column.
  localparam logic [3:0] SBOX [8][64] = '{
    '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
       0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
       4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
      15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
    '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
       3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
       0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
      13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
    '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
      13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
      13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
       1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
    '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
      13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
      10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
       3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
    '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
      14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
       4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
      11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
    '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
      10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
       9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
       4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
    '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
      13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
       1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
       6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
    '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
       1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
       7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
       2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
  };

endpackage

`default_nettype wire
